// File: game.f
design/game_pkg.sv
design/move_if.sv
design/move_entry.sv
design/board_keeper.sv
design/score_board.sv
design/game_top.sv
dv/game_monitor.sv
dv/game_chk.sv
dv/tb_game.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_game
FILELIST  := game.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides, the simulator exit status alone is not enough
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_game.sv
`timescale 1ns/10ps
`default_nettype none

module tb_game;

	localparam int hold_cycles        = 4;
	localparam int error_phase_cycles = 3;
	localparam int win_phase_cycles   = 5;

	// worst case after a submit: hold-off, full scan, full win blink, some slack
	localparam int settle_cycles = hold_cycles + 100 + 4 * win_phase_cycles + 16;
	localparam int press_cycles  = hold_cycles + 5; // low cycle plus hold-off and gap
	localparam int row_cycles    = 9 * press_cycles + settle_cycles + 5; // 5 is max idle gap

	logic             clock_builtin_50MHZ = 1'b0;
	logic             reset;
	logic             not_logic_0;
	logic             not_logic_1;
	logic             not_activity;
	logic [7:0]       in_shift_reg;
	game_pkg::digit_t move_count_tens;
	game_pkg::digit_t move_count_ones;
	game_pkg::digit_t win_count_tens;
	game_pkg::digit_t win_count_ones;
	game_pkg::coord_t last_x;
	game_pkg::coord_t last_y;

	// stimulus table, one entry per row in each queue
	string      names[$];
	logic [7:0] bits_q[$];    // bit 7 pressed first
	bit         submit_q[$];
	logic [7:0] exp_reg_q[$];
	int         exp_moves_q[$];
	int         exp_wins_q[$];
	int         exp_x_q[$];
	int         exp_y_q[$];
	bit         table_ready = 1'b0;

	always #10 clock_builtin_50MHZ = ~clock_builtin_50MHZ; // 50 MHz

	game_top #(
		.hold_cycles        (hold_cycles),
		.error_phase_cycles (error_phase_cycles),
		.win_phase_cycles   (win_phase_cycles)
	) u_game_top (
		.clock_builtin_50MHZ (clock_builtin_50MHZ),
		.reset               (reset),
		.not_logic_0         (not_logic_0),
		.not_logic_1         (not_logic_1),
		.not_activity        (not_activity),
		.in_shift_reg        (in_shift_reg),
		.move_count_tens     (move_count_tens),
		.move_count_ones     (move_count_ones),
		.win_count_tens      (win_count_tens),
		.win_count_ones      (win_count_ones),
		.last_x              (last_x),
		.last_y              (last_y)
	);

	game_monitor u_monitor (
		.clock_builtin_50MHZ (clock_builtin_50MHZ),
		.reset               (reset),
		.in_shift_reg        (in_shift_reg),
		.move_count_tens     (move_count_tens),
		.move_count_ones     (move_count_ones),
		.win_count_tens      (win_count_tens),
		.win_count_ones      (win_count_ones),
		.last_x              (last_x),
		.last_y              (last_y)
	);

	// button order for a move: y lsb first, then x lsb first
	function automatic logic [7:0] entry_bits(input int x, input int y);
		logic [3:0] cx;
		logic [3:0] cy;

		cx = 4'(x);
		cy = 4'(y);
		return {cy[0], cy[1], cy[2], cy[3], cx[0], cx[1], cx[2], cx[3]};
	endfunction

	task automatic add_row(input string name, input logic [7:0] bits, input bit submit,
	                       input logic [7:0] exp_reg, input int moves, input int wins,
	                       input int lx, input int ly);
		names.push_back(name);
		bits_q.push_back(bits);
		submit_q.push_back(submit);
		exp_reg_q.push_back(exp_reg);
		exp_moves_q.push_back(moves);
		exp_wins_q.push_back(wins);
		exp_x_q.push_back(lx);
		exp_y_q.push_back(ly);
	endtask

	task automatic add_move(input string name, input int x, input int y,
	                        input logic [7:0] exp_reg, input int moves, input int wins,
	                        input int lx, input int ly);
		add_row(name, entry_bits(x, y), 1'b1, exp_reg, moves, wins, lx, ly);
	endtask

	// ========================================
	// stimulus table
	// ========================================
	task automatic build_table();
		// name, x, y, expected leds, moves, wins, last x, last y
		add_row("bits_a5", 8'ha5, 1'b0, 8'ha5, 0, 0, 0, 0);
		add_row("bits_3c", 8'h3c, 1'b0, 8'h3c, 0, 0, 0, 0);
		add_move("x_out_of_range", 12, 2, 8'h00, 0, 0, 0, 0);
		add_move("y_out_of_range", 3, 10, 8'h00, 0, 0, 0, 0);
		add_move("place_2_3", 2, 3, 8'h32, 1, 0, 2, 3);
		add_move("resubmit_2_3", 2, 3, 8'h00, 1, 0, 2, 3); // occupied
		add_move("place_5_1", 5, 1, 8'h15, 2, 0, 5, 1);
		add_move("place_9_9", 9, 9, 8'h99, 3, 0, 9, 9);
		add_move("place_0_7", 0, 7, 8'h70, 4, 0, 0, 7);
		add_move("place_7_5", 7, 5, 8'h57, 5, 0, 7, 5);
		add_move("place_4_8", 4, 8, 8'h84, 6, 0, 4, 8);
		add_move("place_1_0", 1, 0, 8'h01, 7, 0, 1, 0);
		add_move("place_8_2", 8, 2, 8'h28, 8, 0, 8, 2);
		add_move("place_6_6", 6, 6, 8'h66, 9, 0, 6, 6);
		add_move("place_3_9", 3, 9, 8'h93, 10, 0, 3, 9); // carry into tens
		add_move("row_2_4", 2, 4, 8'h42, 11, 0, 2, 4);
		add_move("row_3_4", 3, 4, 8'h43, 12, 0, 3, 4);
		add_move("row_4_4", 4, 4, 8'h44, 13, 0, 4, 4);
		add_move("row_win_5_4", 5, 4, 8'h00, 0, 1, 4, 4); // last position kept
		add_move("reuse_2_3", 2, 3, 8'h32, 1, 1, 2, 3);   // grid was cleared
		add_move("col_7_0", 7, 0, 8'h07, 2, 1, 7, 0);
		add_move("col_7_1", 7, 1, 8'h17, 3, 1, 7, 1);
		add_move("col_7_2", 7, 2, 8'h27, 4, 1, 7, 2);
		add_move("col_win_7_3", 7, 3, 8'h00, 0, 2, 7, 2);
		add_move("diag_1_1", 1, 1, 8'h11, 1, 2, 1, 1);
		add_move("diag_2_2", 2, 2, 8'h22, 2, 2, 2, 2);
		add_move("diag_3_3", 3, 3, 8'h33, 3, 2, 3, 3);
		add_move("diag_win_4_4", 4, 4, 8'h00, 0, 3, 3, 3);
		add_move("anti_8_1", 8, 1, 8'h18, 1, 3, 8, 1);
		add_move("anti_7_2", 7, 2, 8'h27, 2, 3, 7, 2);
		add_move("anti_6_3", 6, 3, 8'h36, 3, 3, 6, 3);
		add_move("anti_win_5_4", 5, 4, 8'h00, 0, 4, 6, 3);
	endtask

	// one active low press, starts and ends on a falling edge
	task automatic press_bit(input logic value);
		if (value)
			not_logic_1 = 1'b0;
		else
			not_logic_0 = 1'b0;
		@(negedge clock_builtin_50MHZ);
		not_logic_0 = 1'b1;
		not_logic_1 = 1'b1;
		repeat (hold_cycles + 4) @(negedge clock_builtin_50MHZ); // outlast the hold-off
	endtask

	task automatic press_submit();
		not_activity = 1'b0;
		@(negedge clock_builtin_50MHZ);
		not_activity = 1'b1;
	endtask

	// watchdog, twice the longest possible table run
	initial
	begin
		longint limit_ns;

		wait (table_ready);
		limit_ns = 2 * 20 * (longint'(names.size()) * row_cycles + 20);
		#(limit_ns);
		$display("watchdog expired, the stimulus table did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	// ========================================
	// main sequence
	// ========================================
	initial
	begin
		int gap;
		int total_errors;

		void'($urandom(50));
		reset        = 1'b1;
		not_logic_0  = 1'b1;
		not_logic_1  = 1'b1;
		not_activity = 1'b1;
		build_table();
		table_ready = 1'b1;

		repeat (3) @(posedge clock_builtin_50MHZ); // 3 cycles of reset
		@(negedge clock_builtin_50MHZ);
		reset = 1'b0;
		repeat (2) @(negedge clock_builtin_50MHZ);
		u_monitor.compare_outputs("reset", 8'h00, 0, 0, 0, 0);

		for (int r = 0; r < names.size(); r++)
		begin
			gap = int'($urandom_range(5, 1)); // idle between rows
			repeat (gap) @(negedge clock_builtin_50MHZ);
			for (int b = 7; b >= 0; b--)
			begin
				press_bit(bits_q[r][b]);
			end
			if (submit_q[r])
				press_submit();
			repeat (settle_cycles) @(negedge clock_builtin_50MHZ);
			u_monitor.compare_outputs(names[r], exp_reg_q[r], exp_moves_q[r],
			                          exp_wins_q[r], exp_x_q[r], exp_y_q[r]);
		end

		repeat (2) @(negedge clock_builtin_50MHZ);
		total_errors = u_monitor.error_count + u_monitor.range_errors +
		               u_game_top.u_board.u_chk.fail_count;
		$display("checks %0d, mismatches %0d, range errors %0d, assertion failures %0d",
		         u_monitor.check_count, u_monitor.error_count, u_monitor.range_errors,
		         u_game_top.u_board.u_chk.fail_count);
		if (total_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/game_chk.sv
`timescale 1ns/10ps
`default_nettype none

module game_chk
(
	input logic            clock_builtin_50MHZ,
	input logic            reset,
	input logic            move_valid,
	input logic            move_rejected,
	input logic            move_placed,
	input logic            move_won,
	input game_pkg::cell_t target_cell // grid cell at the move address
);

	logic pending; // a move waits for its verdict
	logic verdict;
	int   fail_count = 0;

	assign verdict = move_rejected || move_placed || move_won;

	always_ff @(posedge clock_builtin_50MHZ)
	begin
		if (reset)
			pending <= 1'b0;
		else if (move_valid)
			pending <= 1'b1;
		else if (verdict)
			pending <= 1'b0; // verdict closes the move
	end

	// ========================================
	// move handshake
	// ========================================
	a_one_verdict: assert property (@(posedge clock_builtin_50MHZ) disable iff (reset)
		$onehot0({move_rejected, move_placed, move_won}))
	else
	begin
		$error("more than one verdict pulse in the same cycle");
		fail_count++;
	end

	// next move only once the last one got its verdict
	a_no_overlap: assert property (@(posedge clock_builtin_50MHZ) disable iff (reset)
		move_valid |-> !pending)
	else
	begin
		$error("new move before the verdict of the previous one");
		fail_count++;
	end

	a_verdict_pending: assert property (@(posedge clock_builtin_50MHZ) disable iff (reset)
		verdict |-> pending)
	else
	begin
		$error("verdict pulse without a move in flight");
		fail_count++;
	end

	// occupancy answer comes two cycles after the move
	a_taken_rejected: assert property (@(posedge clock_builtin_50MHZ) disable iff (reset)
		(move_valid && (target_cell == game_pkg::cell_triangle)) |-> ##2 move_rejected)
	else
	begin
		$error("move onto a marked cell was not rejected");
		fail_count++;
	end

	a_free_accepted: assert property (@(posedge clock_builtin_50MHZ) disable iff (reset)
		(move_valid && (target_cell == game_pkg::cell_empty)) |-> ##2 !move_rejected)
	else
	begin
		$error("move onto a free cell was rejected");
		fail_count++;
	end

endmodule

bind board_keeper game_chk u_chk
(
	.clock_builtin_50MHZ (clock_builtin_50MHZ),
	.reset               (reset),
	.move_valid          (move.move_valid),
	.move_rejected       (move.move_rejected),
	.move_placed         (move.move_placed),
	.move_won            (move.move_won),
	.target_cell         (grid[move.move_y][move.move_x])
);

`default_nettype wire

// File: dv/game_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module game_monitor
(
	input logic             clock_builtin_50MHZ,
	input logic             reset,
	input logic [7:0]       in_shift_reg,
	input game_pkg::digit_t move_count_tens,
	input game_pkg::digit_t move_count_ones,
	input game_pkg::digit_t win_count_tens,
	input game_pkg::digit_t win_count_ones,
	input game_pkg::coord_t last_x,
	input game_pkg::coord_t last_y
);

	int error_count  = 0; // value mismatches
	int check_count  = 0; // fields compared
	int range_errors = 0; // digits seen outside 0..9

	// one field against its expected value
	task automatic check_value(input string test_name, input string field,
	                           input int expected, input int actual);
		check_count++;
		if (actual != expected)
		begin
			$display("FAILED %s %s: expected 'h%0h, actual 'h%0h",
			         test_name, field, expected, actual);
			error_count++;
		end
	endtask

	// ========================================
	// compare on request from the testbench
	// ========================================
	// counts come in as plain numbers, split into two decimal digits here
	task automatic compare_outputs(input string test_name, input logic [7:0] exp_reg,
	                               input int exp_moves, input int exp_wins,
	                               input int exp_x, input int exp_y);
		check_value(test_name, "in_shift_reg", int'(exp_reg), int'(in_shift_reg));
		check_value(test_name, "move_count_tens", exp_moves / 10, int'(move_count_tens));
		check_value(test_name, "move_count_ones", exp_moves % 10, int'(move_count_ones));
		check_value(test_name, "win_count_tens", exp_wins / 10, int'(win_count_tens));
		check_value(test_name, "win_count_ones", exp_wins % 10, int'(win_count_ones));
		check_value(test_name, "last_x", exp_x, int'(last_x));
		check_value(test_name, "last_y", exp_y, int'(last_y));
	endtask

	// display digits stay decimal at all times, not only at the checks
	always @(negedge clock_builtin_50MHZ)
	begin
		if (!reset && ((move_count_tens > 4'd9) || (move_count_ones > 4'd9) ||
		               (win_count_tens > 4'd9) || (win_count_ones > 4'd9)))
		begin
			$display("a count digit left the decimal range 0 to 9 at %0t", $time);
			range_errors++;
		end
	end

endmodule

`default_nettype wire

// File: design/game_top.sv
`timescale 1ns/10ps
`default_nettype none

module game_top #(
	parameter int hold_cycles        = 15000000,  // about 300 ms at 50 MHz
	parameter int error_phase_cycles = 12500000,  // 250 ms per error phase
	parameter int win_phase_cycles   = 125000000  // 2.5 s per win phase
)
(
	input  logic             clock_builtin_50MHZ,
	input  logic             reset,
	input  logic             not_logic_0,
	input  logic             not_logic_1,
	input  logic             not_activity,
	output logic [7:0]       in_shift_reg,
	output game_pkg::digit_t move_count_tens,
	output game_pkg::digit_t move_count_ones,
	output game_pkg::digit_t win_count_tens,
	output game_pkg::digit_t win_count_ones,
	output game_pkg::coord_t last_x,
	output game_pkg::coord_t last_y
);

	// shared move and verdict signals
	move_if u_move ();

	// ========================================
	// buttons, leds and blinking
	// ========================================
	move_entry #(
		.hold_cycles        (hold_cycles),
		.error_phase_cycles (error_phase_cycles),
		.win_phase_cycles   (win_phase_cycles)
	) u_entry (
		.clock_builtin_50MHZ (clock_builtin_50MHZ),
		.reset               (reset),
		.not_logic_0         (not_logic_0),
		.not_logic_1         (not_logic_1),
		.not_activity        (not_activity),
		.in_shift_reg        (in_shift_reg),
		.move                (u_move.entry)
	);

	// grid, occupancy and run scan
	board_keeper u_board (
		.clock_builtin_50MHZ (clock_builtin_50MHZ),
		.reset               (reset),
		.move                (u_move.board)
	);

	// display counts
	score_board u_score (
		.clock_builtin_50MHZ (clock_builtin_50MHZ),
		.reset               (reset),
		.move                (u_move.score),
		.move_count_tens     (move_count_tens),
		.move_count_ones     (move_count_ones),
		.win_count_tens      (win_count_tens),
		.win_count_ones      (win_count_ones),
		.last_x              (last_x),
		.last_y              (last_y)
	);

endmodule

`default_nettype wire

// File: design/score_board.sv
`timescale 1ns/10ps
`default_nettype none

module score_board
(
	input  logic             clock_builtin_50MHZ,
	input  logic             reset,
	move_if.score            move,
	output game_pkg::digit_t move_count_tens,
	output game_pkg::digit_t move_count_ones,
	output game_pkg::digit_t win_count_tens,
	output game_pkg::digit_t win_count_ones,
	output game_pkg::coord_t last_x,
	output game_pkg::coord_t last_y
);

	localparam game_pkg::digit_t top_digit = 4'd9;

	// two-digit decimal increment, returns {tens, ones}, 99 wraps to 00
	function automatic logic [7:0] dec_inc(input game_pkg::digit_t tens,
	                                       input game_pkg::digit_t ones);
		logic [7:0] result;

		if (ones != top_digit)
		begin
			result = {tens, ones + 4'd1};
		end
		else if (tens != top_digit)
		begin
			result = {tens + 4'd1, 4'd0}; // carry into tens
		end
		else
		begin
			result = 8'h00;
		end
		return result;
	endfunction

	// ========================================
	// counters and last position
	// ========================================
	always_ff @(posedge clock_builtin_50MHZ)
	begin
		if (reset)
		begin
			move_count_tens <= '0;
			move_count_ones <= '0;
			win_count_tens  <= '0;
			win_count_ones  <= '0;
			last_x          <= '0;
			last_y          <= '0;
		end
		else if (move.move_won)
		begin
			// new round, last position is kept
			move_count_tens <= '0;
			move_count_ones <= '0;
			{win_count_tens, win_count_ones} <= dec_inc(win_count_tens, win_count_ones);
		end
		else if (move.move_placed)
		begin
			last_x <= move.move_x;
			last_y <= move.move_y;
			{move_count_tens, move_count_ones} <= dec_inc(move_count_tens, move_count_ones);
		end
	end

endmodule

`default_nettype wire

// File: design/board_keeper.sv
`timescale 1ns/10ps
`default_nettype none

module board_keeper
(
	input  logic  clock_builtin_50MHZ,
	input  logic  reset,
	move_if.board move
);

	localparam int last_index = game_pkg::board_size - 1;
	localparam game_pkg::coord_t last_coord = game_pkg::coord_t'(last_index);

	// scan directions: right, down, down-right, down-left
	localparam int step_x [4] = '{1, 0, 1, -1};
	localparam int step_y [4] = '{0, 1, 1, 1};

	typedef enum logic [1:0]
	{
		bk_idle,     // no move in flight
		bk_checking, // occupancy of the addressed cell
		bk_scanning  // one start cell per cycle
	} bk_state_t;

	bk_state_t        state;
	game_pkg::cell_t  grid [game_pkg::board_size][game_pkg::board_size]; // [y][x]
	game_pkg::coord_t scan_x;
	game_pkg::coord_t scan_y;
	logic             cell_taken;
	logic             run_found;
	logic             clear_grid;

	assign cell_taken = (grid[move.move_y][move.move_x] == game_pkg::cell_triangle);
	assign clear_grid = (state == bk_scanning) && run_found; // same edge as move_won

	// ========================================
	// run test at the current start cell
	// ========================================
	always_comb
	begin
		int   end_x;
		int   end_y;
		int   px;
		int   py;
		logic all_marked;

		end_x      = 0;
		end_y      = 0;
		px         = 0;
		py         = 0;
		all_marked = 1'b0;
		run_found  = 1'b0;
		for (int d = 0; d < 4; d++)
		begin
			// last cell of the run must still be on the board
			end_x = int'(scan_x) + step_x[d] * (game_pkg::run_length - 1);
			end_y = int'(scan_y) + step_y[d] * (game_pkg::run_length - 1);
			if ((end_x >= 0) && (end_x <= last_index) && (end_y <= last_index))
			begin
				all_marked = 1'b1;
				for (int i = 0; i < game_pkg::run_length; i++)
				begin
					px = int'(scan_x) + step_x[d] * i;
					py = int'(scan_y) + step_y[d] * i;
					if (grid[game_pkg::coord_t'(py)][game_pkg::coord_t'(px)] != game_pkg::cell_triangle)
					begin
						all_marked = 1'b0;
					end
				end
				if (all_marked)
				begin
					run_found = 1'b1;
				end
			end
		end
	end

	// grid storage, wiped on reset and after a win
	always_ff @(posedge clock_builtin_50MHZ)
	begin
		if (reset || clear_grid)
		begin
			for (int y = 0; y < game_pkg::board_size; y++)
			begin
				for (int x = 0; x < game_pkg::board_size; x++)
				begin
					grid[y][x] <= game_pkg::cell_empty;
				end
			end
		end
		else if ((state == bk_checking) && !cell_taken)
		begin
			grid[move.move_y][move.move_x] <= game_pkg::cell_triangle; // place the mark
		end
	end

	// ========================================
	// verdict fsm
	// ========================================
	always_ff @(posedge clock_builtin_50MHZ)
	begin
		if (reset)
		begin
			state              <= bk_idle;
			scan_x             <= '0;
			scan_y             <= '0;
			move.move_rejected <= 1'b0;
			move.move_placed   <= 1'b0;
			move.move_won      <= 1'b0;
		end
		else
		begin
			move.move_rejected <= 1'b0; // verdicts are single pulses
			move.move_placed   <= 1'b0;
			move.move_won      <= 1'b0;
			case (state)
				bk_idle:
				begin
					if (move.move_valid)
					begin
						state <= bk_checking;
					end
				end

				bk_checking:
				begin
					if (cell_taken)
					begin
						move.move_rejected <= 1'b1;
						state              <= bk_idle;
					end
					else
					begin
						scan_x <= '0; // mark goes in on this edge, scan from the corner
						scan_y <= '0;
						state  <= bk_scanning;
					end
				end

				bk_scanning:
				begin
					if (run_found)
					begin
						move.move_won <= 1'b1; // first winning start ends the scan
						state         <= bk_idle;
					end
					else if ((scan_x == last_coord) && (scan_y == last_coord))
					begin
						move.move_placed <= 1'b1; // all 100 starts seen
						state            <= bk_idle;
					end
					else if (scan_x == last_coord)
					begin
						scan_x <= '0;
						scan_y <= scan_y + 4'd1;
					end
					else
					begin
						scan_x <= scan_x + 4'd1;
					end
				end

				default:
				begin
					state <= bk_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/move_entry.sv
`timescale 1ns/10ps
`default_nettype none

module move_entry #(
	parameter int hold_cycles        = 15000000,  // debounce hold-off
	parameter int error_phase_cycles = 12500000,  // one error blink phase
	parameter int win_phase_cycles   = 125000000  // one win blink phase
)
(
	input  logic       clock_builtin_50MHZ,
	input  logic       reset,
	input  logic       not_logic_0,  // active low, shifts a 0 in
	input  logic       not_logic_1,  // active low, shifts a 1 in
	input  logic       not_activity, // active low, submits the register
	output logic [7:0] in_shift_reg, // also drives the leds
	move_if.entry      move
);

	// one counter for hold-off and blink phases, sized for the longest
	localparam int max_hold_err = (hold_cycles > error_phase_cycles) ?
		hold_cycles : error_phase_cycles;
	localparam int max_cycles = (max_hold_err > win_phase_cycles) ?
		max_hold_err : win_phase_cycles;
	localparam int cnt_w = $clog2(max_cycles + 1);

	localparam game_pkg::coord_t last_coord = game_pkg::coord_t'(game_pkg::board_size - 1);

	typedef enum logic [2:0]
	{
		st_collecting,  // buttons shift bits in
		st_holding,     // debounce, buttons ignored
		st_submitting,  // decode and range check
		st_waiting,     // move in flight, wait for the verdict
		st_error_blink,
		st_win_blink
	} state_t;

	state_t           state;
	logic [cnt_w-1:0] cnt;            // shared down-counter
	logic [1:0]       phase;          // blink phase 0..3
	logic             submit_pending; // hold-off started by the activity button
	logic [cnt_w-1:0] phase_len;      // reload value of the running blink
	game_pkg::coord_t dec_x;
	game_pkg::coord_t dec_y;
	logic             in_range;

	// ========================================
	// decoding of the entered bits
	// ========================================
	// x and y are entered msb last, so the bit order is reversed
	assign dec_x = {in_shift_reg[0], in_shift_reg[1], in_shift_reg[2], in_shift_reg[3]};
	assign dec_y = {in_shift_reg[4], in_shift_reg[5], in_shift_reg[6], in_shift_reg[7]};
	assign in_range = (dec_x <= last_coord) && (dec_y <= last_coord);

	assign phase_len = (state == st_win_blink) ?
		cnt_w'(win_phase_cycles - 1) : cnt_w'(error_phase_cycles - 1);

	// move payload, stays put while the board works on it
	always_ff @(posedge clock_builtin_50MHZ)
	begin
		if (state == st_submitting)
		begin
			move.move_x <= dec_x;
			move.move_y <= dec_y;
		end
	end

	// ========================================
	// entry fsm
	// ========================================
	always_ff @(posedge clock_builtin_50MHZ)
	begin
		if (reset)
		begin
			state           <= st_collecting;
			cnt             <= '0;
			phase           <= '0;
			submit_pending  <= 1'b0;
			in_shift_reg    <= '0;
			move.move_valid <= 1'b0;
		end
		else
		begin
			move.move_valid <= 1'b0; // pulse lasts one cycle
			case (state)
				st_collecting:
				begin
					if (!not_logic_0) // 0 button wins over the others
					begin
						in_shift_reg <= {in_shift_reg[6:0], 1'b0};
						cnt          <= cnt_w'(hold_cycles);
						state        <= st_holding;
					end
					else if (!not_logic_1)
					begin
						in_shift_reg <= {in_shift_reg[6:0], 1'b1};
						cnt          <= cnt_w'(hold_cycles);
						state        <= st_holding;
					end
					else if (!not_activity)
					begin
						submit_pending <= 1'b1; // judge the move after the hold-off
						cnt            <= cnt_w'(hold_cycles);
						state          <= st_holding;
					end
				end

				st_holding:
				begin
					if (cnt == '0)
					begin
						submit_pending <= 1'b0;
						state          <= submit_pending ? st_submitting : st_collecting;
					end
					else
					begin
						cnt <= cnt - cnt_w'(1);
					end
				end

				st_submitting:
				begin
					if (in_range)
					begin
						move.move_valid <= 1'b1; // payload latched on this edge too
						state           <= st_waiting;
					end
					else
					begin
						in_shift_reg <= 8'hff; // first error phase, leds on
						phase        <= '0;
						cnt          <= cnt_w'(error_phase_cycles - 1);
						state        <= st_error_blink;
					end
				end

				st_waiting:
				begin
					if (move.move_rejected) // occupied cell
					begin
						in_shift_reg <= 8'hff;
						phase        <= '0;
						cnt          <= cnt_w'(error_phase_cycles - 1);
						state        <= st_error_blink;
					end
					else if (move.move_placed)
					begin
						in_shift_reg <= {move.move_y, move.move_x}; // echo, y high and x low
						state        <= st_collecting;
					end
					else if (move.move_won)
					begin
						in_shift_reg <= {move.move_y, move.move_x}; // echo shows for one cycle
						phase        <= '0;
						cnt          <= cnt_w'(win_phase_cycles - 1);
						state        <= st_win_blink;
					end
				end

				// both blinks run on, off, on, off and differ only in phase length
				st_error_blink, st_win_blink:
				begin
					if (cnt == '0)
					begin
						if (phase == 2'd3)
						begin
							in_shift_reg <= '0; // last phase done, back to entry
							state        <= st_collecting;
						end
						else
						begin
							phase        <= phase + 2'd1;
							cnt          <= phase_len;
							in_shift_reg <= phase[0] ? 8'hff : 8'h00; // pattern of the next phase
						end
					end
					else
					begin
						cnt          <= cnt - cnt_w'(1);
						in_shift_reg <= phase[0] ? 8'h00 : 8'hff; // even phases lit
					end
				end

				default:
				begin
					state <= st_collecting;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/move_if.sv
`timescale 1ns/10ps
`default_nettype none

// one move in flight between entry, board and score keeper
interface move_if;

	logic             move_valid;    // one-cycle pulse from entry
	game_pkg::coord_t move_x;        // held from move_valid until the verdict
	game_pkg::coord_t move_y;

	// verdict, exactly one of these pulses per move
	logic move_rejected; // cell already taken
	logic move_placed;   // cell marked, no run on the board
	logic move_won;      // cell marked and a run found

	// ========================================
	// modports
	// ========================================
	modport entry
	(
		output move_valid,
		output move_x,
		output move_y,
		input  move_rejected,
		input  move_placed,
		input  move_won
	);

	modport board
	(
		input  move_valid,
		input  move_x,
		input  move_y,
		output move_rejected,
		output move_placed,
		output move_won
	);

	// score keeper only listens
	modport score
	(
		input move_x,
		input move_y,
		input move_placed,
		input move_won
	);

endinterface

`default_nettype wire

// File: design/game_pkg.sv
`default_nettype none

package game_pkg;

	// ========================================
	// board geometry
	// ========================================

	// cells per side of the square board
	localparam int board_size = 10;

	// marked cells in a row that end the round
	localparam int run_length = 4;

	// ========================================
	// shared types
	// ========================================

	// one coordinate, 0..9 on the board, 10..15 means out of range
	typedef logic [3:0] coord_t;

	// content of one grid cell, only the triangle player is left
	typedef enum logic
	{
		cell_empty    = 1'b0, // free cell
		cell_triangle = 1'b1  // marked by the player
	} cell_t;

	// one decimal digit of a count shown on a display, 0..9
	typedef logic [3:0] digit_t;

endpackage

`default_nettype wire
